// ==== hdl/dcp_defs.svh ====
`ifndef DCP_DEFS_SVH
`define DCP_DEFS_SVH

// CPU field and bus data width
`define DCP_WORD_W 32

// Command byte
`define DCP_CMD_W 8

// NPC, PC, IR, CTL, A, B, IMM, Y, MDR
`define DCP_FIELD_CNT 9

// Longest label without the trailing "="
`define DCP_LABEL_MAX 3

`define DCP_CHAR_EQ 8'h3D
`define DCP_CHAR_CR 8'h0D
`define DCP_CHAR_LF 8'h0A

`endif

// ==== hdl/dcp_pkg.sv ====
`default_nettype none

`include "dcp_defs.svh"

package dcp_pkg;

    typedef struct packed {
        logic [`DCP_WORD_W-1:0] npc;
        logic [`DCP_WORD_W-1:0] pc;
        logic [`DCP_WORD_W-1:0] ir;
        logic [`DCP_WORD_W-1:0] ctl;
        logic [`DCP_WORD_W-1:0] a;
        logic [`DCP_WORD_W-1:0] b;
        logic [`DCP_WORD_W-1:0] imm;
        logic [`DCP_WORD_W-1:0] y;
        logic [`DCP_WORD_W-1:0] mdr;
    } cpu_fields_t;

    typedef logic [3:0] field_idx_t;

    typedef struct packed {
        logic [0:`DCP_LABEL_MAX-1][7:0] chars; // First char in chars[0]
        logic [1:0]                     len;
    } label_t;

    typedef struct packed {
        logic                   is_word;
        logic [`DCP_WORD_W-1:0] data;    // Char code in low byte
    } tx_item_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic                   adr;     // 0 char, 1 word
        logic [`DCP_WORD_W-1:0] dat;
    } wb_m2s_t;

    typedef enum logic [2:0] {IDLE, PULSE, SETTLE, DUMP, HOLD} step_state_t;

    typedef enum logic [2:0] {PH_LABEL, PH_EQ, PH_WORD, PH_CR, PH_LF, PH_DONE} dump_phase_t;

    typedef enum logic [1:0] {TX_IDLE, TX_BUS, TX_GAP} tx_state_t;

endpackage

`default_nettype wire

// ==== hdl/dcp_label_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcp_label_rom (
    input  wire dcp_pkg::field_idx_t idx,
    output dcp_pkg::label_t          label
);

    always_comb begin
        case (idx)
            4'd0: begin
                label.chars = "NPC";
                label.len   = 2'd3;
            end
            4'd1: begin
                label.chars = {"PC", 8'h00};
                label.len   = 2'd2;
            end
            4'd2: begin
                label.chars = {"IR", 8'h00};
                label.len   = 2'd2;
            end
            4'd3: begin
                label.chars = "CTL";
                label.len   = 2'd3;
            end
            4'd4: begin
                label.chars = {"A", 16'h0000};
                label.len   = 2'd1;
            end
            4'd5: begin
                label.chars = {"B", 16'h0000};
                label.len   = 2'd1;
            end
            4'd6: begin
                label.chars = "IMM";
                label.len   = 2'd3;
            end
            4'd7: begin
                label.chars = {"Y", 16'h0000};
                label.len   = 2'd1;
            end
            4'd8: begin
                label.chars = "MDR";
                label.len   = 2'd3;
            end
            default: begin
                label.chars = {"?", 16'h0000}; // Out of range index
                label.len   = 2'd1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/dcp_step_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcp_defs.svh"

module dcp_step_ctrl (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire [`DCP_CMD_W-1:0] sel_mode,
    input  wire [`DCP_CMD_W-1:0] cmd_id,
    input  wire                  dump_done,
    output logic                 clk_cpu,
    output logic                 run,
    output logic                 done
);

    dcp_pkg::step_state_t state;
    logic                 match;

    assign match = (sel_mode == cmd_id);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= dcp_pkg::IDLE;
            clk_cpu <= 1'b0;
            run     <= 1'b0;
            done    <= 1'b0;
        end else if (!match) begin
            // Command withdrawn ends the session in any state
            state   <= dcp_pkg::IDLE;
            clk_cpu <= 1'b0;
            run     <= 1'b0;
            done    <= 1'b0;
        end else begin
            case (state)
                dcp_pkg::IDLE: begin
                    state   <= dcp_pkg::PULSE;
                    clk_cpu <= 1'b1;            // Single step
                end
                dcp_pkg::PULSE: begin
                    state   <= dcp_pkg::SETTLE;
                    clk_cpu <= 1'b0;
                end
                dcp_pkg::SETTLE: begin
                    state <= dcp_pkg::DUMP;     // Let the datapath settle
                    run   <= 1'b1;
                end
                dcp_pkg::DUMP: begin
                    if (dump_done) begin
                        state <= dcp_pkg::HOLD;
                        run   <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                dcp_pkg::HOLD: begin
                    done <= 1'b1;               // Until sel_mode changes
                end
                default: begin
                    state   <= dcp_pkg::IDLE;
                    clk_cpu <= 1'b0;
                    run     <= 1'b0;
                    done    <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcp_dump_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcp_defs.svh"

module dcp_dump_seq (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       run,
    input  wire dcp_pkg::cpu_fields_t fields,
    output dcp_pkg::tx_item_t         item,
    output logic                      item_valid,
    input  wire                       item_taken,
    output logic                      dump_done
);

    dcp_pkg::dump_phase_t   phase;
    dcp_pkg::field_idx_t    fidx;
    logic [1:0]             cidx;
    logic                   drain;      // Aborted item still on the bus
    logic [`DCP_WORD_W-1:0] word_q;
    logic [`DCP_WORD_W-1:0] field_word;
    dcp_pkg::label_t        label;
    logic                   last_char;
    logic                   taken;

    dcp_label_rom u_rom (
        .idx   (fidx),
        .label (label)
    );

    always_comb begin
        case (fidx)
            4'd0:    field_word = fields.npc;
            4'd1:    field_word = fields.pc;
            4'd2:    field_word = fields.ir;
            4'd3:    field_word = fields.ctl;
            4'd4:    field_word = fields.a;
            4'd5:    field_word = fields.b;
            4'd6:    field_word = fields.imm;
            4'd7:    field_word = fields.y;
            default: field_word = fields.mdr;
        endcase
    end

    assign last_char = (cidx == label.len - 2'd1);
    assign taken     = item_valid && item_taken;
    assign dump_done = taken && (phase == dcp_pkg::PH_LF);

    always_comb begin
        item.is_word = 1'b0;
        item.data    = '0;
        case (phase)
            dcp_pkg::PH_LABEL: item.data[7:0] = label.chars[cidx];
            dcp_pkg::PH_EQ:    item.data[7:0] = `DCP_CHAR_EQ;
            dcp_pkg::PH_WORD: begin
                item.is_word = 1'b1;
                item.data    = word_q;
            end
            dcp_pkg::PH_CR:    item.data[7:0] = `DCP_CHAR_CR;
            dcp_pkg::PH_LF:    item.data[7:0] = `DCP_CHAR_LF;
            default:           item.data      = '0;
        endcase
    end

    // Word is captured as it becomes the current item
    always_ff @(posedge clk) begin
        if (taken && phase == dcp_pkg::PH_EQ) begin
            word_q <= field_word;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase      <= dcp_pkg::PH_LABEL;
            fidx       <= '0;
            cidx       <= '0;
            item_valid <= 1'b0;
            drain      <= 1'b0;
        end else if (!run) begin
            phase      <= dcp_pkg::PH_LABEL;
            fidx       <= '0;
            cidx       <= '0;
            item_valid <= 1'b0;
            if (item_taken) begin
                drain <= 1'b0;
            end else if (item_valid) begin
                drain <= 1'b1;          // Its item_taken is still to come
            end
        end else if (drain) begin
            if (item_taken) begin
                drain <= 1'b0;
            end
        end else if (!item_valid) begin
            item_valid <= (phase != dcp_pkg::PH_DONE);
        end else if (item_taken) begin
            case (phase)
                dcp_pkg::PH_LABEL: begin
                    if (last_char) begin
                        phase <= dcp_pkg::PH_EQ;
                        cidx  <= '0;
                    end else begin
                        cidx <= cidx + 2'd1;
                    end
                end
                dcp_pkg::PH_EQ: phase <= dcp_pkg::PH_WORD;
                dcp_pkg::PH_WORD: begin
                    if (fidx == dcp_pkg::field_idx_t'(`DCP_FIELD_CNT - 1)) begin
                        phase <= dcp_pkg::PH_CR;
                    end else begin
                        fidx  <= fidx + 4'd1;
                        phase <= dcp_pkg::PH_LABEL;
                    end
                end
                dcp_pkg::PH_CR: phase <= dcp_pkg::PH_LF;
                default: begin
                    phase      <= dcp_pkg::PH_DONE; // Idle until run falls
                    item_valid <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcp_tx_master.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcp_defs.svh"

module dcp_tx_master (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire dcp_pkg::tx_item_t  item,
    input  wire                     item_valid,
    output logic                    item_taken,
    output dcp_pkg::wb_m2s_t        wb,
    input  wire                     wb_ack
);

    dcp_pkg::tx_state_t     state;
    logic                   adr_q;
    logic [`DCP_WORD_W-1:0] dat_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= dcp_pkg::TX_IDLE;
        end else begin
            case (state)
                dcp_pkg::TX_IDLE: begin
                    if (item_valid) begin
                        state <= dcp_pkg::TX_BUS;
                    end
                end
                dcp_pkg::TX_BUS: begin
                    if (wb_ack) begin
                        state <= dcp_pkg::TX_GAP;   // No abort once started
                    end
                end
                default: state <= dcp_pkg::TX_IDLE;
            endcase
        end
    end

    // Payload held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == dcp_pkg::TX_IDLE && item_valid) begin
            adr_q <= item.is_word;
            dat_q <= item.data;
        end
    end

    always_comb begin
        wb.cyc = (state == dcp_pkg::TX_BUS);
        wb.stb = (state == dcp_pkg::TX_BUS);
        wb.we  = (state == dcp_pkg::TX_BUS);   // Write only
        wb.adr = adr_q;
        wb.dat = dat_q;
    end

    // Bus idle cycle doubles as the taken pulse
    assign item_taken = (state == dcp_pkg::TX_GAP);

endmodule

`default_nettype wire

// ==== hdl/dcp_trace_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcp_defs.svh"

module dcp_trace_top (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire [`DCP_CMD_W-1:0]      sel_mode,
    input  wire [`DCP_CMD_W-1:0]      cmd_id,
    input  wire dcp_pkg::cpu_fields_t fields,
    input  wire                       wb_ack,
    output dcp_pkg::wb_m2s_t          wb,
    output logic                      clk_cpu,
    output logic                      done
);

    logic              run;
    logic              dump_done;
    logic              item_valid;
    logic              item_taken;
    dcp_pkg::tx_item_t item;

    dcp_step_ctrl u_step (
        .clk       (clk),
        .rstn      (rstn),
        .sel_mode  (sel_mode),
        .cmd_id    (cmd_id),
        .dump_done (dump_done),
        .clk_cpu   (clk_cpu),
        .run       (run),
        .done      (done)
    );

    dcp_dump_seq u_seq (
        .clk        (clk),
        .rstn       (rstn),
        .run        (run),
        .fields     (fields),
        .item       (item),
        .item_valid (item_valid),
        .item_taken (item_taken),
        .dump_done  (dump_done)
    );

    dcp_tx_master u_tx (
        .clk        (clk),
        .rstn       (rstn),
        .item       (item),
        .item_valid (item_valid),
        .item_taken (item_taken),
        .wb         (wb),
        .wb_ack     (wb_ack)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_wb_sink.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcp_defs.svh"

module tb_wb_sink (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire dcp_pkg::wb_m2s_t  wb,
    output logic                   ack,
    output int unsigned            rec_cnt
);

    logic [`DCP_WORD_W:0] rec_q[$];      // {adr, dat} per transfer
    logic [31:0]          seed;
    int                   wait_left;
    logic                 busy;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        ack       = 1'b0;
        rec_cnt   = 0;
        seed      = 32'h25d8_2655;
        busy      = 1'b0;
        wait_left = 0;
    end

    always @(posedge clk) begin
        logic                   stb_s;
        logic                   ack_s;
        logic                   adr_s;
        logic [`DCP_WORD_W-1:0] dat_s;
        stb_s = wb.cyc && wb.stb;          // Sampled before the edge updates
        ack_s = ack;
        adr_s = wb.adr;
        dat_s = wb.dat;
        #2;
        if (!rstn) begin
            ack  = 1'b0;
            busy = 1'b0;
        end else if (ack_s && stb_s) begin
            rec_q.push_back({adr_s, dat_s});
            rec_cnt = rec_q.size();
            ack     = 1'b0;
            busy    = 1'b0;
        end else if (stb_s && !busy) begin
            seed      = lcg_next(seed);
            wait_left = int'(seed[17:16]); // 0 to 3 extra cycles
            busy      = 1'b1;
            if (wait_left == 0) ack = 1'b1;
        end else if (stb_s && !ack) begin
            wait_left = wait_left - 1;
            if (wait_left <= 0) ack = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_dcp_trace.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcp_defs.svh"

module tb_dcp_trace;

    logic                  clk;
    logic                  rstn;
    logic [`DCP_CMD_W-1:0] sel_mode;
    logic [`DCP_CMD_W-1:0] cmd_id;
    dcp_pkg::cpu_fields_t  fields;
    logic                  wb_ack;
    dcp_pkg::wb_m2s_t      wb;
    logic                  clk_cpu;
    logic                  done;

    int unsigned          rec_cnt;
    int                   err_cnt;
    int unsigned          pulse_cnt;
    int unsigned          pulse_base;
    int unsigned          exp_base;
    int unsigned          exp_cnt;
    logic [`DCP_WORD_W:0] exp_mem[0:63];
    logic [`DCP_WORD_W:0] exp_head;
    int unsigned          exp_idx;
    logic                 idle_check;
    string                lbl[0:8] = '{"NPC", "PC", "IR", "CTL", "A", "B", "IMM", "Y", "MDR"};

    dcp_trace_top dut0 (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .cmd_id   (cmd_id),
        .fields   (fields),
        .wb_ack   (wb_ack),
        .wb       (wb),
        .clk_cpu  (clk_cpu),
        .done     (done)
    );

    tb_wb_sink sink0 (
        .clk     (clk),
        .rstn    (rstn),
        .wb      (wb),
        .ack     (wb_ack),
        .rec_cnt (rec_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rstn && clk_cpu) pulse_cnt <= pulse_cnt + 1;
    end

    assign exp_idx  = rec_cnt - exp_base;
    assign exp_head = exp_mem[exp_idx[5:0]];

    a_idle: assert property (@(posedge clk) disable iff (!rstn)
        idle_check |-> (!wb.cyc && !wb.stb && !clk_cpu && !done))
        else begin
            err_cnt++;
            $display("MISMATCH %0t: activity without a command match", $time);
        end
    a_write: assert property (@(posedge clk) disable iff (!rstn)
        (wb.cyc || wb.stb) |-> (wb.cyc && wb.stb && wb.we))
        else begin
            err_cnt++;
            $display("MISMATCH %0t: bus cycle without a write strobe", $time);
        end
    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        (wb.stb && !wb_ack) |=> (wb.stb && $stable(wb.dat) && $stable(wb.adr)))
        else begin
            err_cnt++;
            $display("MISMATCH %0t: transfer changed before ack", $time);
        end
    a_gap: assert property (@(posedge clk) disable iff (!rstn)
        (wb.stb && wb_ack) |=> !wb.stb)
        else begin
            err_cnt++;
            $display("MISMATCH %0t: no idle cycle after ack", $time);
        end
    a_pulse: assert property (@(posedge clk) disable iff (!rstn) clk_cpu |=> !clk_cpu)
        else begin
            err_cnt++;
            $display("MISMATCH %0t: clk_cpu high longer than one cycle", $time);
        end
    a_order: assert property (@(posedge clk) disable iff (!rstn)
        $rose(wb.stb) |-> (pulse_cnt > pulse_base && !clk_cpu))
        else begin
            err_cnt++;
            $display("MISMATCH %0t: transfer before the CPU pulse", $time);
        end
    a_done: assert property (@(posedge clk) disable iff (!rstn)
        done |-> (!wb.cyc && !clk_cpu))
        else begin
            err_cnt++;
            $display("MISMATCH %0t: bus or pulse activity while done", $time);
        end
    a_stream: assert property (@(posedge clk) disable iff (!rstn)
        (wb.stb && wb_ack) |-> (exp_idx < exp_cnt && {wb.adr, wb.dat} == exp_head))
        else begin
            err_cnt++;
            $display("MISMATCH %0t: transfer %0d got %h expected %h", $time,
                exp_idx, {wb.adr, wb.dat}, exp_head);
        end

    function automatic logic [`DCP_WORD_W-1:0] field_value(input dcp_pkg::cpu_fields_t f,
                                                           input int i);
        case (i)
            0:       return f.npc;
            1:       return f.pc;
            2:       return f.ir;
            3:       return f.ctl;
            4:       return f.a;
            5:       return f.b;
            6:       return f.imm;
            7:       return f.y;
            default: return f.mdr;
        endcase
    endfunction

    // Labels, "=", value word, then CR LF
    task automatic build_expected();
        int n;
        n = 0;
        for (int i = 0; i < `DCP_FIELD_CNT; i++) begin
            for (int c = 0; c < lbl[i].len(); c++) begin
                exp_mem[n] = {1'b0, 24'h0, lbl[i].getc(c)};
                n++;
            end
            exp_mem[n]     = {1'b0, 24'h0, `DCP_CHAR_EQ};
            exp_mem[n + 1] = {1'b1, field_value(fields, i)};
            n = n + 2;
        end
        exp_mem[n]     = {1'b0, 24'h0, `DCP_CHAR_CR};
        exp_mem[n + 1] = {1'b0, 24'h0, `DCP_CHAR_LF};
        exp_cnt  = n + 2;
        exp_base = rec_cnt;
    endtask

    task automatic set_fields(input logic [7:0] tag);
        for (int i = 0; i < `DCP_FIELD_CNT; i++) begin
            fields[(`DCP_FIELD_CNT-1-i)*32 +: 32] = {tag, 8'(i), 16'h5a00 ^ 16'(i * 977)};
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors: %0d", err_cnt);
        $display("Test failed");
        $finish;
    endtask

    task automatic wait_done(input logic level, input int limit);
        int n;
        n = 0;
        while (done !== level && n < limit) begin
            step(1);
            n++;
        end
        if (done !== level) stop_on_timeout("done to change");
    endtask

    task automatic wait_transfers(input int unsigned cnt, input int limit);
        int n;
        n = 0;
        while (rec_cnt - exp_base < cnt && n < limit) begin
            step(1);
            n++;
        end
        if (rec_cnt - exp_base < cnt) stop_on_timeout("transfers in a dump");
    endtask

    task automatic wait_bus_idle(input int limit);
        int n;
        n = 0;
        while (wb.cyc && n < limit) begin
            step(1);
            n++;
        end
        if (wb.cyc) stop_on_timeout("the bus to go idle");
    endtask

    task automatic full_session(input logic [7:0] tag);
        int unsigned held;
        set_fields(tag);
        build_expected();
        pulse_base = pulse_cnt;
        sel_mode   = cmd_id;
        wait_done(1'b1, 2000);
        assert (rec_cnt - exp_base == exp_cnt && pulse_cnt == pulse_base + 1) else begin
            err_cnt++;
            $display("MISMATCH %0t: %0d transfers, %0d pulses at done", $time,
                rec_cnt - exp_base, pulse_cnt - pulse_base);
        end
        held = rec_cnt;
        step(20);
        assert (done && rec_cnt == held && pulse_cnt == pulse_base + 1) else begin
            err_cnt++;
            $display("MISMATCH %0t: session did not hold after done", $time);
        end
        sel_mode = ~cmd_id;
        wait_done(1'b0, 4);
    endtask

    initial begin
        int unsigned snap;
        rstn       = 1'b0;
        cmd_id     = 8'h5A;
        sel_mode   = 8'h00;
        fields     = '0;
        err_cnt    = 0;
        pulse_cnt  = 0;
        pulse_base = 0;
        exp_base   = 0;
        exp_cnt    = 0;
        idle_check = 1'b0;
        for (int i = 0; i < 64; i++) exp_mem[i] = '0;
        repeat (2) @(posedge clk);
        #2;
        rstn       = 1'b1;
        idle_check = 1'b1;
        step(10);
        idle_check = 1'b0;

        full_session(8'hA1);

        // Abort in the middle of a dump
        set_fields(8'hB2);
        build_expected();
        pulse_base = pulse_cnt;
        sel_mode   = cmd_id;
        wait_transfers(7, 500);
        sel_mode = 8'h33;
        step(2);
        #1;                                  // Past the sink's update for this edge
        snap = rec_cnt + (wb.cyc ? 1 : 0);   // In-flight transfer still completes
        exp_cnt = snap - exp_base;
        wait_bus_idle(20);
        step(15);
        assert (rec_cnt == snap && !done && !wb.cyc) else begin
            err_cnt++;
            $display("MISMATCH %0t: activity after abort, %0d transfers of %0d", $time,
                rec_cnt, snap);
        end

        full_session(8'hC3);

        $display("Errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/dcp_pkg.sv
hdl/dcp_label_rom.sv
hdl/dcp_step_ctrl.sv
hdl/dcp_dump_seq.sv
hdl/dcp_tx_master.sv
hdl/dcp_trace_top.sv
testbench/tb_wb_sink.sv
testbench/tb_dcp_trace.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the trace unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_dcp_trace \
    -o sim_dcp_trace
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dcp_trace > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
